//--- Bender.yml
package:
  name: mem_region

sources:
  - mem_region_pkg.sv
  - sp_ram.sv
  - ram_arbiter.sv
  - lsu_router.sv
  - mem_region.sv
  - target: test
    files:
      - tb_mem_region.sv

//--- lsu_router.sv
module lsu_router
  import mem_region_pkg::*;
#(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,

  // core load/store port
  input  logic                    core_req_i,
  input  logic [ADDR_W-1:0]       core_addr_i,
  input  logic                    core_we_i,
  input  logic [CORE_BE_W-1:0]    core_be_i,
  input  logic [CORE_DATA_W-1:0]  core_wdata_i,
  output logic                    core_gnt_o,
  output logic                    core_rvalid_o,
  output logic [CORE_DATA_W-1:0]  core_rdata_o,

  // external master port
  output logic                    ext_req_o,
  output logic [ADDR_W-1:0]       ext_addr_o,
  output logic                    ext_we_o,
  output logic [CORE_BE_W-1:0]    ext_be_o,
  output logic [CORE_DATA_W-1:0]  ext_wdata_o,
  input  logic                    ext_gnt_i,
  input  logic                    ext_rvalid_i,
  input  logic [CORE_DATA_W-1:0]  ext_rdata_i,

  // local RAM port
  output logic                    loc_req_o,
  output logic [ADDR_W-1:0]       loc_addr_o,
  output logic                    loc_we_o,
  output logic [CORE_BE_W-1:0]    loc_be_o,
  output logic [CORE_DATA_W-1:0]  loc_wdata_o,
  input  logic                    loc_gnt_i,
  input  logic                    loc_rvalid_i,
  input  logic [CORE_DATA_W-1:0]  loc_rdata_i
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic             is_local;
  logic             can_issue;
  logic             accept;
  logic [CNT_W-1:0] cnt_q;
  // target of the responses still pending
  logic             pend_local_q;

  assign is_local = (core_addr_i[ADDR_W-1 -: $bits(LOCAL_PREFIX)] == LOCAL_PREFIX);

  // stay in order: only one target may have responses in flight
  assign can_issue = (cnt_q < CNT_W'(MAX_OUTSTANDING)) &&
                     ((cnt_q == '0) || (pend_local_q == is_local));

  assign loc_req_o = core_req_i &  is_local & can_issue;
  assign ext_req_o = core_req_i & ~is_local & can_issue;

  assign loc_addr_o  = core_addr_i;
  assign loc_we_o    = core_we_i;
  assign loc_be_o    = core_be_i;
  assign loc_wdata_o = core_wdata_i;

  assign ext_addr_o  = core_addr_i;
  assign ext_we_o    = core_we_i;
  assign ext_be_o    = core_be_i;
  assign ext_wdata_o = core_wdata_i;

  assign core_gnt_o = (loc_req_o & loc_gnt_i) | (ext_req_o & ext_gnt_i);
  assign accept     = core_gnt_o;

  // never both at once, only one target is pending
  assign core_rvalid_o = loc_rvalid_i | ext_rvalid_i;
  assign core_rdata_o  = loc_rvalid_i ? loc_rdata_i : ext_rdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q        <= '0;
      pend_local_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + CNT_W'(accept) - CNT_W'(core_rvalid_o);
      if (accept) begin
        pend_local_q <= is_local;
      end
    end
  end

  a_cnt_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_W'(MAX_OUTSTANDING)
  );

  // a response needs a pending request from the same target
  a_loc_resp: assert property (
    @(posedge clk) disable iff (!rst_n)
    loc_rvalid_i |-> (cnt_q != '0) && pend_local_q
  );

  a_ext_resp: assert property (
    @(posedge clk) disable iff (!rst_n)
    ext_rvalid_i |-> (cnt_q != '0) && !pend_local_q
  );

endmodule

//--- mem_region.f
mem_region_pkg.sv
sp_ram.sv
ram_arbiter.sv
lsu_router.sv
mem_region.sv
tb_mem_region.sv

//--- mem_region.sv
module mem_region
  import mem_region_pkg::*;
#(
  parameter int RAM_BYTES       = 32768,
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,

  // core load/store port
  input  logic                    core_req_i,
  input  logic [ADDR_W-1:0]       core_addr_i,
  input  logic                    core_we_i,
  input  logic [CORE_BE_W-1:0]    core_be_i,
  input  logic [CORE_DATA_W-1:0]  core_wdata_i,
  output logic                    core_gnt_o,
  output logic                    core_rvalid_o,
  output logic [CORE_DATA_W-1:0]  core_rdata_o,

  // external master port
  output logic                    ext_req_o,
  output logic [ADDR_W-1:0]       ext_addr_o,
  output logic                    ext_we_o,
  output logic [CORE_BE_W-1:0]    ext_be_o,
  output logic [CORE_DATA_W-1:0]  ext_wdata_o,
  input  logic                    ext_gnt_i,
  input  logic                    ext_rvalid_i,
  input  logic [CORE_DATA_W-1:0]  ext_rdata_i,

  // 64-bit bus slave port
  input  logic                    bus_req_i,
  input  logic [ADDR_W-1:0]       bus_addr_i,
  input  logic                    bus_we_i,
  input  logic [BUS_BE_W-1:0]     bus_be_i,
  input  logic [BUS_DATA_W-1:0]   bus_wdata_i,
  output logic                    bus_rvalid_o,
  output logic [BUS_DATA_W-1:0]   bus_rdata_o
);

  localparam int RAM_AW = $clog2(RAM_BYTES / BUS_BE_W);

  // router to arbiter
  logic                   loc_req;
  logic [ADDR_W-1:0]      loc_addr;
  logic                   loc_we;
  logic [CORE_BE_W-1:0]   loc_be;
  logic [CORE_DATA_W-1:0] loc_wdata;
  logic                   loc_gnt;
  logic                   loc_rvalid;
  logic [CORE_DATA_W-1:0] loc_rdata;

  // arbiter to RAM
  logic                   ram_en;
  logic [RAM_AW-1:0]      ram_addr;
  logic                   ram_we;
  logic [BUS_BE_W-1:0]    ram_be;
  ram_word_u              ram_wdata;
  ram_word_u              ram_rdata;

  lsu_router #(
    .MAX_OUTSTANDING ( MAX_OUTSTANDING )
  ) u_lsu_router (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .core_req_i    ( core_req_i    ),
    .core_addr_i   ( core_addr_i   ),
    .core_we_i     ( core_we_i     ),
    .core_be_i     ( core_be_i     ),
    .core_wdata_i  ( core_wdata_i  ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .ext_req_o     ( ext_req_o     ),
    .ext_addr_o    ( ext_addr_o    ),
    .ext_we_o      ( ext_we_o      ),
    .ext_be_o      ( ext_be_o      ),
    .ext_wdata_o   ( ext_wdata_o   ),
    .ext_gnt_i     ( ext_gnt_i     ),
    .ext_rvalid_i  ( ext_rvalid_i  ),
    .ext_rdata_i   ( ext_rdata_i   ),
    .loc_req_o     ( loc_req       ),
    .loc_addr_o    ( loc_addr      ),
    .loc_we_o      ( loc_we        ),
    .loc_be_o      ( loc_be        ),
    .loc_wdata_o   ( loc_wdata     ),
    .loc_gnt_i     ( loc_gnt       ),
    .loc_rvalid_i  ( loc_rvalid    ),
    .loc_rdata_i   ( loc_rdata     )
  );

  ram_arbiter #(
    .RAM_BYTES ( RAM_BYTES )
  ) u_ram_arbiter (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .bus_req_i    ( bus_req_i    ),
    .bus_addr_i   ( bus_addr_i   ),
    .bus_we_i     ( bus_we_i     ),
    .bus_be_i     ( bus_be_i     ),
    .bus_wdata_i  ( bus_wdata_i  ),
    .bus_rvalid_o ( bus_rvalid_o ),
    .bus_rdata_o  ( bus_rdata_o  ),
    .loc_req_i    ( loc_req      ),
    .loc_addr_i   ( loc_addr     ),
    .loc_we_i     ( loc_we       ),
    .loc_be_i     ( loc_be       ),
    .loc_wdata_i  ( loc_wdata    ),
    .loc_gnt_o    ( loc_gnt      ),
    .loc_rvalid_o ( loc_rvalid   ),
    .loc_rdata_o  ( loc_rdata    ),
    .ram_en_o     ( ram_en       ),
    .ram_addr_o   ( ram_addr     ),
    .ram_we_o     ( ram_we       ),
    .ram_be_o     ( ram_be       ),
    .ram_wdata_o  ( ram_wdata    ),
    .ram_rdata_i  ( ram_rdata    )
  );

  sp_ram #(
    .RAM_BYTES ( RAM_BYTES )
  ) u_sp_ram (
    .clk     ( clk       ),
    .rst_n   ( rst_n     ),
    .en_i    ( ram_en    ),
    .addr_i  ( ram_addr  ),
    .we_i    ( ram_we    ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

//--- mem_region_pkg.sv
package mem_region_pkg;

  // core load/store port
  localparam int ADDR_W      = 32;
  localparam int CORE_DATA_W = 32;
  localparam int CORE_BE_W   = CORE_DATA_W / 8;

  // bus slave port and RAM word
  localparam int BUS_DATA_W  = 64;
  localparam int BUS_BE_W    = BUS_DATA_W / 8;

  // 32-bit lanes per RAM word
  localparam int LANES       = BUS_DATA_W / CORE_DATA_W;

  // address bits 31 to 20 that select the local RAM
  localparam logic [11:0] LOCAL_PREFIX = 12'h001;

  // one RAM word, seen whole by the bus or as lanes by the core
  // lane 0 is the low half, picked by core address bit 2
  typedef union packed {
    logic [BUS_DATA_W-1:0]                 word;
    logic [LANES-1:0][CORE_DATA_W-1:0]     lane;
  } ram_word_u;

endpackage

//--- ram_arbiter.sv
module ram_arbiter
  import mem_region_pkg::*;
#(
  parameter int RAM_BYTES = 32768
) (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // bus slave port that always wins
  input  logic                                   bus_req_i,
  input  logic [ADDR_W-1:0]                      bus_addr_i,
  input  logic                                   bus_we_i,
  input  logic [BUS_BE_W-1:0]                    bus_be_i,
  input  logic [BUS_DATA_W-1:0]                  bus_wdata_i,
  output logic                                   bus_rvalid_o,
  output logic [BUS_DATA_W-1:0]                  bus_rdata_o,

  // local core requests from the router
  input  logic                                   loc_req_i,
  input  logic [ADDR_W-1:0]                      loc_addr_i,
  input  logic                                   loc_we_i,
  input  logic [CORE_BE_W-1:0]                   loc_be_i,
  input  logic [CORE_DATA_W-1:0]                 loc_wdata_i,
  output logic                                   loc_gnt_o,
  output logic                                   loc_rvalid_o,
  output logic [CORE_DATA_W-1:0]                 loc_rdata_o,

  // RAM side
  output logic                                   ram_en_o,
  output logic [$clog2(RAM_BYTES/BUS_BE_W)-1:0]  ram_addr_o,
  output logic                                   ram_we_o,
  output logic [BUS_BE_W-1:0]                    ram_be_o,
  output ram_word_u                              ram_wdata_o,
  input  ram_word_u                              ram_rdata_i
);

  localparam int RAM_AW = $clog2(RAM_BYTES / BUS_BE_W);
  // byte offset inside a RAM word
  localparam int OFF    = $clog2(BUS_BE_W);
  localparam int LANE_W = $clog2(LANES);

  logic [LANE_W-1:0] lane_sel;
  logic [LANE_W-1:0] lane_q;
  logic              bus_served_q;
  logic              loc_served_q;

  // lane bits sit just below the word offset
  assign lane_sel = loc_addr_i[OFF-1 -: LANE_W];

  always_comb begin
    ram_wdata_o = '0;
    ram_be_o    = '0;
    loc_gnt_o   = 1'b0;
    if (bus_req_i) begin
      ram_en_o         = 1'b1;
      ram_addr_o       = bus_addr_i[OFF +: RAM_AW];
      ram_we_o         = bus_we_i;
      ram_be_o         = bus_be_i;
      ram_wdata_o.word = bus_wdata_i;
    end else begin
      ram_en_o   = loc_req_i;
      loc_gnt_o  = loc_req_i;
      ram_addr_o = loc_addr_i[OFF +: RAM_AW];
      ram_we_o   = loc_we_i;
      // place core data and enables into the addressed lane
      ram_wdata_o.lane[lane_sel]                  = loc_wdata_i;
      ram_be_o[lane_sel*CORE_BE_W +: CORE_BE_W] = loc_be_i;
    end
  end

  // remember who owns next cycle's read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_served_q <= 1'b0;
      loc_served_q <= 1'b0;
      lane_q       <= '0;
    end else begin
      bus_served_q <= bus_req_i;
      loc_served_q <= loc_gnt_o;
      if (loc_gnt_o) begin
        lane_q <= lane_sel;
      end
    end
  end

  assign bus_rvalid_o = bus_served_q;
  assign bus_rdata_o  = ram_rdata_i.word;
  assign loc_rvalid_o = loc_served_q;
  assign loc_rdata_o  = ram_rdata_i.lane[lane_q];

  // core is never granted while the bus holds the RAM
  a_no_gnt_on_bus: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(loc_gnt_o && bus_req_i)
  );

endmodule

//--- sp_ram.sv
module sp_ram
  import mem_region_pkg::*;
#(
  parameter int RAM_BYTES = 32768
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   en_i,
  input  logic [$clog2(RAM_BYTES/BUS_BE_W)-1:0]  addr_i,
  input  logic                                   we_i,
  input  logic [BUS_BE_W-1:0]                    be_i,
  input  ram_word_u                              wdata_i,
  output ram_word_u                              rdata_o
);

  localparam int WORDS = RAM_BYTES / BUS_BE_W;

  logic [BUS_DATA_W-1:0] mem [WORDS];

  // read first, so a write returns the old word
  always_ff @(posedge clk) begin
    if (en_i) begin
      rdata_o.word <= mem[addr_i];
      if (we_i) begin
        for (int b = 0; b < BUS_BE_W; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i.word[b*8 +: 8];
          end
        end
      end
    end
  end

  // word address must hit a real entry
  a_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    en_i |-> (int'(addr_i) < WORDS)
  );

endmodule

//--- tb_mem_region.sv
module tb_mem_region;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] LOC_BASE  = 32'h0010_0000;
  localparam logic [31:0] EXT_BASE  = 32'h4000_0000;
  localparam int          WIN_BYTES = 512;
  localparam int          TIMEOUT   = 200;

  logic        clk;
  logic        rst_n;
  logic        core_req_i;
  logic [31:0] core_addr_i;
  logic        core_we_i;
  logic [3:0]  core_be_i;
  logic [31:0] core_wdata_i;
  logic        core_gnt_o;
  logic        core_rvalid_o;
  logic [31:0] core_rdata_o;
  logic        ext_req_o;
  logic [31:0] ext_addr_o;
  logic        ext_we_o;
  logic [3:0]  ext_be_o;
  logic [31:0] ext_wdata_o;
  logic        ext_gnt_i;
  logic        ext_rvalid_i;
  logic [31:0] ext_rdata_i;
  logic        bus_req_i;
  logic [31:0] bus_addr_i;
  logic        bus_we_i;
  logic [7:0]  bus_be_i;
  logic [63:0] bus_wdata_i;
  logic        bus_rvalid_o;
  logic [63:0] bus_rdata_o;

  // byte model of the RAM window under test
  logic [7:0]  ram_model [WIN_BYTES];
  // expected core responses in acceptance order
  // a due cycle of -1 marks an external response
  logic [31:0] exp_data_q [$];
  bit          exp_read_q [$];
  int          exp_due_q [$];
  logic [31:0] ext_resp_q [$];

  int          err_cnt;
  int          conflicts;
  int          ext_acc;
  int          cyc;
  bit          core_acc;
  bit          noise_en;
  bit          bus_due;
  bit          bus_due_read;
  logic [63:0] bus_exp;

  mem_region #(
    .RAM_BYTES       ( 32768 ),
    .MAX_OUTSTANDING ( 4     )
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] ext_read_value(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h3c3c_c3c3;
  endfunction

  function automatic logic [63:0] word_from_model(input int off);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = ram_model[(off & ~7) + b];
    end
    return w;
  endfunction

  // lane 0 is the low half of the word
  function automatic logic [31:0] lane_from_model(input int off);
    logic [63:0] w;
    w = word_from_model(off);
    return off[2] ? w[63:32] : w[31:0];
  endfunction

  task automatic store_bytes(input int off, input logic [7:0] be, input logic [63:0] data);
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        ram_model[(off & ~7) + b] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("%s", what);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Error: %s got %0h expected %0h", name, got, exp);
    end
  endtask

  // sampled 1 ns after the falling edge when all outputs have settled
  task automatic check_cycle();
    logic [31:0] exp;
    bit          rd;
    int          due;
    int          off;
    // responses belong to grants of earlier cycles
    if (core_rvalid_o) begin
      assert (exp_data_q.size() != 0) else report_failure("core response with nothing pending");
      if (exp_data_q.size() != 0) begin
        exp = exp_data_q.pop_front();
        rd  = exp_read_q.pop_front();
        due = exp_due_q.pop_front();
        if (due >= 0) begin
          check_value("core_rvalid_o cycle", cyc, due);
        end
        if (rd) begin
          check_value("core_rdata_o", core_rdata_o, exp);
        end
      end
    end else if (exp_due_q.size() != 0) begin
      assert (exp_due_q[0] != cyc) else
        report_failure("local core response missing one cycle after its grant");
    end
    check_value("bus_rvalid_o", bus_rvalid_o, bus_due);
    if (bus_due && bus_due_read) begin
      check_value("bus_rdata_o", bus_rdata_o, bus_exp);
    end
    bus_due = 1'b0;
    if (bus_req_i) begin
      off          = int'(bus_addr_i[8:0]);
      bus_due      = 1'b1;
      bus_due_read = !bus_we_i;
      bus_exp      = word_from_model(off);
      if (bus_we_i) begin
        store_bytes(off, bus_be_i, bus_wdata_i);
      end
      if (core_req_i && core_addr_i[31:20] == 12'h001) begin
        conflicts++;
        check_value("core_gnt_o", core_gnt_o, 1'b0);
      end
    end
    core_acc = core_req_i && core_gnt_o;
    if (core_acc && core_addr_i[31:20] == 12'h001) begin
      off = int'(core_addr_i[8:0]);
      exp_data_q.push_back(lane_from_model(off));
      exp_read_q.push_back(!core_we_i);
      exp_due_q.push_back(cyc + 1);
      if (core_we_i) begin
        store_bytes(off, off[2] ? {core_be_i, 4'h0} : {4'h0, core_be_i},
                    {core_wdata_i, core_wdata_i});
      end
    end else if (core_acc) begin
      ext_acc++;
      check_value("ext_addr_o", ext_addr_o, core_addr_i);
      check_value("ext_we_o", ext_we_o, core_we_i);
      check_value("ext_be_o", ext_be_o, core_be_i);
      check_value("ext_wdata_o", ext_wdata_o, core_wdata_i);
      exp_data_q.push_back(ext_read_value(core_addr_i));
      exp_read_q.push_back(!core_we_i);
      exp_due_q.push_back(-1);
      ext_resp_q.push_back(core_we_i ? 32'h0 : ext_read_value(core_addr_i));
    end
    if (ext_req_o) begin
      assert (core_addr_i[31:20] != 12'h001) else
        report_failure("local address appeared on the external port");
    end
    cyc++;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (rst_n) begin
        check_cycle();
      end
    end
  end

  // external slave with random grants and response delays
  initial begin
    int delay;
    delay = 0;
    forever begin
      @(negedge clk);
      ext_gnt_i = ($urandom_range(99) < 60);
      if (ext_resp_q.size() != 0 && delay == 0) begin
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = ext_resp_q.pop_front();
        delay        = $urandom_range(3);
      end else begin
        ext_rvalid_i = 1'b0;
        ext_rdata_i  = $urandom();
        if (delay > 0) begin
          delay--;
        end
      end
    end
  end

  // background bus traffic to force conflicts with the core
  initial begin
    forever begin
      @(negedge clk);
      if (noise_en) begin
        bus_req_i   = ($urandom_range(99) < 35);
        bus_addr_i  = LOC_BASE | 32'($urandom_range(WIN_BYTES - 1));
        bus_we_i    = $urandom_range(1);
        bus_be_i    = 8'($urandom());
        bus_wdata_i = {$urandom(), $urandom()};
      end
    end
  end

  task automatic core_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata);
    int waited;
    @(negedge clk);
    core_req_i   = 1'b1;
    core_addr_i  = addr;
    core_we_i    = we;
    core_be_i    = be;
    core_wdata_i = wdata;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!core_acc && waited < TIMEOUT);
    assert (core_acc) else
      report_failure($sformatf("core request to %h was never granted", addr));
  endtask

  task automatic core_idle();
    @(negedge clk);
    core_req_i = 1'b0;
  endtask

  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [7:0] be,
                            input logic [63:0] wdata);
    @(negedge clk);
    bus_req_i   = 1'b1;
    bus_addr_i  = addr;
    bus_we_i    = we;
    bus_be_i    = be;
    bus_wdata_i = wdata;
  endtask

  task automatic bus_idle();
    @(negedge clk);
    bus_req_i = 1'b0;
  endtask

  task automatic run_core_stream(input int n, input int ext_pct);
    logic [31:0] addr;
    for (int i = 0; i < n; i++) begin
      addr = ($urandom_range(99) < ext_pct) ? EXT_BASE : LOC_BASE;
      addr = addr | (32'($urandom_range(WIN_BYTES - 1)) & 32'hffff_fffc);
      core_access(addr, $urandom_range(1), 4'($urandom()), $urandom());
      if ($urandom_range(3) == 0) begin
        core_idle();
      end
    end
    core_idle();
  endtask

  // bus words against core lanes in both directions
  task automatic lane_crosscheck(input int n);
    logic [31:0] base;
    for (int i = 0; i < n; i++) begin
      base = LOC_BASE | (32'($urandom_range(WIN_BYTES / 8 - 1)) << 3);
      bus_access(base, 1'b1, 8'($urandom()), {$urandom(), $urandom()});
      bus_idle();
      core_access(base, 1'b0, 4'hf, '0);
      core_access(base | 32'h4, 1'b0, 4'hf, '0);
      core_access(base | (32'(i % 2) << 2), 1'b1, 4'($urandom()), $urandom());
      core_idle();
      bus_access(base, 1'b0, 8'h00, '0);
      bus_idle();
    end
  endtask

  initial begin
    int waited;
    void'($urandom(32'h5ca1));
    rst_n        = 1'b0;
    core_req_i   = 1'b0;
    core_addr_i  = '0;
    core_we_i    = 1'b0;
    core_be_i    = '0;
    core_wdata_i = '0;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    bus_req_i    = 1'b0;
    bus_addr_i   = '0;
    bus_we_i     = 1'b0;
    bus_be_i     = '0;
    bus_wdata_i  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value("core_rvalid_o", core_rvalid_o, 1'b0);
    check_value("bus_rvalid_o", bus_rvalid_o, 1'b0);
    check_value("ext_req_o", ext_req_o, 1'b0);

    // known contents for the whole window
    for (int w = 0; w < WIN_BYTES / 8; w++) begin
      bus_access(LOC_BASE + 32'(w * 8), 1'b1, 8'hff, {$urandom(), $urandom()});
    end
    bus_idle();

    run_core_stream(150, 0);
    lane_crosscheck(40);
    @(posedge clk);
    noise_en = 1'b1;
    run_core_stream(150, 0);
    run_core_stream(200, 50);
    @(posedge clk);
    noise_en = 1'b0;
    bus_idle();

    waited = 0;
    while (exp_data_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_data_q.size() == 0) else
      report_failure("core responses still missing at the end of the run");
    assert (conflicts > 0) else report_failure("no bus and core conflict was exercised");
    assert (ext_acc > 0) else report_failure("no external access was accepted");

    $display("errors: %0d, conflicts: %0d, external accesses: %0d", err_cnt, conflicts, ext_acc);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
